//--- hw/instr_dup_pkg.sv
package instr_dup_pkg;

   // ==============================
   // widths and duplicate-half constants
   // ==============================
   localparam int INSTR_W     = 32;
   localparam int REG_ADDR_W  = 5;
   localparam int DUP_REG_BIT = 4;                             // regs 16..31 are the twins
   localparam logic [REG_ADDR_W-1:0] DUP_R0P = 5'd16;          // duplicate zero register
   localparam logic [5:0] DUP_MEM_PREFIX     = 6'b000001;      // upper half of 128B memory

   // fp format field, low bits of funct7
   localparam logic [1:0] FMT_S = 2'b00;
   localparam logic [1:0] FMT_D = 2'b01;

   // ==============================
   // opcodes and function codes
   // ==============================
   typedef enum logic [6:0] {
      LOAD     = 7'b0000011,
      STORE    = 7'b0100011,
      OP_IMM   = 7'b0010011,
      OP       = 7'b0110011,
      JAL      = 7'b1101111,
      JALR     = 7'b1100111,
      BRANCH   = 7'b1100011,
      LUI      = 7'b0110111,
      AUIPC    = 7'b0010111,
      AMO      = 7'b0101111,
      LOAD_FP  = 7'b0000111,
      STORE_FP = 7'b0100111,
      OP_FP    = 7'b1010011,
      MADD     = 7'b1000011,
      MSUB     = 7'b1000111,
      NMSUB    = 7'b1001011,
      NMADD    = 7'b1001111
   } opcode_e;

   // one member per distinct code, the other names alias these below
   typedef enum logic [2:0] {
      LB  = 3'b000,
      LH  = 3'b001,
      LW  = 3'b010,
      FLD = 3'b011,
      LBU = 3'b100,
      LHU = 3'b101
   } funct3_e;

   localparam funct3_e SB     = LB;
   localparam funct3_e SH     = LH;
   localparam funct3_e SW     = LW;
   localparam funct3_e FLH    = LH;
   localparam funct3_e FLW    = LW;
   localparam funct3_e FLQ    = LBU;
   localparam funct3_e FMV    = LB;
   localparam funct3_e FCLASS = LH;

   // R3 and compare ops, single format (low two bits = fmt)
   typedef enum logic [6:0] {
      FADD     = 7'b00000_00,
      FSUB     = 7'b00001_00,
      FMUL     = 7'b00010_00,
      FDIV     = 7'b00011_00,
      FSGNJ    = 7'b00100_00,
      FMIN_MAX = 7'b00101_00,
      FCMP     = 7'b10100_00
   } fp_funct7_e;

   // R2 ops, funct12 = {funct7, rs2}
   typedef enum logic [11:0] {
      FSQRT_S   = 12'b0101100_00000,
      FSQRT_D   = 12'b0101101_00000,
      FCVT_S_D  = 12'b0100000_00001,
      FCVT_D_S  = 12'b0100001_00000,
      FCVT_S_W  = 12'b1101000_00000,
      FCVT_S_WU = 12'b1101000_00001,
      FCVT_D_W  = 12'b1101001_00000,
      FCVT_D_WU = 12'b1101001_00001,
      FMV_W_X   = 12'b1111000_00000,
      FCVT_W_S  = 12'b1100000_00000,
      FCVT_WU_S = 12'b1100000_00001,
      FCVT_W_D  = 12'b1100001_00000,
      FCVT_WU_D = 12'b1100001_00001,
      FMV_X_W   = 12'b1110000_00000,
      FCLASS_D  = 12'b1110001_00000
   } fp_funct12_e;

   localparam fp_funct12_e FCLASS_S = FMV_X_W; // told apart by funct3

   // ==============================
   // instruction and class
   // ==============================
   typedef struct packed {
      logic [6:0]            funct7;
      logic [REG_ADDR_W-1:0] rs2;
      logic [REG_ADDR_W-1:0] rs1;
      logic [2:0]            funct3;
      logic [REG_ADDR_W-1:0] rd;
      logic [6:0]            opcode;
   } rv_instr_t;

   typedef enum logic [4:0] {
      CLS_NONE,
      CLS_LOAD,
      CLS_STORE,
      CLS_ALU_REG,
      CLS_ALU_IMM,
      CLS_JAL,
      CLS_JALR,
      CLS_UPPER,       // lui and auipc
      CLS_BRANCH,
      CLS_AMO,
      CLS_FP_R2,
      CLS_FP_R3,
      CLS_FP_R4,
      CLS_FP_R2_F_I,   // int source, fp dest
      CLS_FP_R2_I_F,   // fp source, int dest
      CLS_FP_R3_I_FF,
      CLS_FP_LOAD,
      CLS_FP_STORE
   } dup_class_e;

   // twin register index, same for int and fp files
   function automatic logic [REG_ADDR_W-1:0] map_reg(input logic [REG_ADDR_W-1:0] idx);
      logic [REG_ADDR_W-1:0] dup;
      dup = idx;
      dup[DUP_REG_BIT] = 1'b1;
      return dup;
   endfunction

endpackage

//--- hw/dup_classifier.sv
`timescale 1ns/10ps

module dup_classifier import instr_dup_pkg::*; (
   input  rv_instr_t  instr_i,
   output dup_class_e cls_o
);

   logic [11:0] funct12;
   logic [6:0]  fp_op7;    // funct7 with fmt forced to single
   logic        fmt_ok;

   logic ld_width;
   logic st_width;
   logic f_width;          // fp load/store and amo widths

   logic r2_f;
   logic r3_f;
   logic r2_f_i;
   logic r2_i_f;
   logic r3_i_ff;

   assign funct12 = {instr_i.funct7, instr_i.rs2};
   assign fp_op7  = {instr_i.funct7[6:2], FMT_S};
   assign fmt_ok  = instr_i.funct7[1:0] inside {FMT_S, FMT_D};

   assign ld_width = instr_i.funct3 inside {LB, LH, LW, LBU, LHU};
   assign st_width = instr_i.funct3 inside {SB, SH, SW};
   assign f_width  = instr_i.funct3 inside {FLH, FLW, FLD, FLQ};

   // ==============================
   // fp sub-decode
   // ==============================
   assign r2_f = funct12 inside {FSQRT_S, FSQRT_D, FCVT_S_D, FCVT_D_S};

   assign r3_f = fmt_ok &&
                 (fp_op7 inside {FADD, FSUB, FMUL, FDIV, FSGNJ, FMIN_MAX});

   assign r2_f_i = (funct12 inside {FCVT_S_W, FCVT_S_WU, FCVT_D_W, FCVT_D_WU}) ||
                   ((funct12 == FMV_W_X) && (instr_i.funct3 == FMV));

   assign r2_i_f = (funct12 inside {FCVT_W_S, FCVT_WU_S, FCVT_W_D, FCVT_WU_D}) ||
                   ((funct12 == FMV_X_W) && (instr_i.funct3 == FMV)) ||
                   ((funct12 inside {FCLASS_S, FCLASS_D}) &&
                    (instr_i.funct3 == FCLASS));

   assign r3_i_ff = fmt_ok && (fp_op7 == FCMP);

   // ==============================
   // class select
   // ==============================
   always_comb begin
      cls_o = CLS_NONE;
      case (instr_i.opcode)
         LOAD: begin
            if (ld_width) cls_o = CLS_LOAD;
         end
         STORE: begin
            if (st_width) cls_o = CLS_STORE;
         end
         OP:            cls_o = CLS_ALU_REG;    // includes mul/div
         OP_IMM:        cls_o = CLS_ALU_IMM;
         JAL:           cls_o = CLS_JAL;
         JALR:          cls_o = CLS_JALR;
         LUI, AUIPC:    cls_o = CLS_UPPER;
         BRANCH:        cls_o = CLS_BRANCH;
         AMO: begin
            if (f_width) cls_o = CLS_AMO;
         end
         OP_FP: begin
            if (r2_f)
               cls_o = CLS_FP_R2;
            else if (r3_f)
               cls_o = CLS_FP_R3;
            else if (r2_f_i)
               cls_o = CLS_FP_R2_F_I;
            else if (r2_i_f)
               cls_o = CLS_FP_R2_I_F;
            else if (r3_i_ff)
               cls_o = CLS_FP_R3_I_FF;
         end
         MADD, MSUB, NMSUB, NMADD: cls_o = CLS_FP_R4;
         LOAD_FP: begin
            if (f_width) cls_o = CLS_FP_LOAD;
         end
         STORE_FP: begin
            if (f_width) cls_o = CLS_FP_STORE;
         end
         default:       cls_o = CLS_NONE;
      endcase
   end

endmodule

//--- hw/int_dup_rewriter.sv
`timescale 1ns/10ps

module int_dup_rewriter import instr_dup_pkg::*; (
   input  rv_instr_t  instr_i,
   input  dup_class_e cls_i,
   output rv_instr_t  int_dup_o
);

   logic [REG_ADDR_W-1:0] dup_rd;
   logic [REG_ADDR_W-1:0] dup_rs1;
   logic [REG_ADDR_W-1:0] dup_rs2;
   logic [6:0]            mem_hi;

   assign dup_rd  = map_reg(instr_i.rd);
   assign dup_rs1 = map_reg(instr_i.rs1);
   assign dup_rs2 = map_reg(instr_i.rs2);

   // imm[11:5] for loads and stores alike, keeps imm[5] only
   // so the access lands in the upper 64B
   assign mem_hi = {DUP_MEM_PREFIX, instr_i.funct7[0]};

   // ==============================
   // per class field rewrite
   // ==============================
   always_comb begin
      int_dup_o = instr_i;
      case (cls_i)
         CLS_LOAD: begin
            int_dup_o.funct7 = mem_hi;   // imm[4:0] stays in rs2 slot
            int_dup_o.rs1    = dup_rs1;
            int_dup_o.rd     = dup_rd;
         end
         CLS_STORE: begin
            int_dup_o.funct7 = mem_hi;   // imm[4:0] stays in rd slot
            int_dup_o.rs2    = dup_rs2;
            int_dup_o.rs1    = dup_rs1;
         end
         CLS_ALU_REG: begin
            int_dup_o.rs2 = dup_rs2;
            int_dup_o.rs1 = dup_rs1;
            int_dup_o.rd  = dup_rd;
         end
         CLS_ALU_IMM, CLS_JALR: begin
            int_dup_o.rs1 = dup_rs1;
            int_dup_o.rd  = dup_rd;
         end
         CLS_JAL, CLS_UPPER: begin
            int_dup_o.rd = dup_rd;       // upper twenty bits untouched
         end
         CLS_BRANCH: begin
            int_dup_o.rs2 = dup_rs2;
            int_dup_o.rs1 = dup_rs1;
         end
         CLS_AMO: begin
            int_dup_o.rs2 = dup_rs2;
            int_dup_o.rs1 = DUP_R0P;     // address base is the twin zero reg
            int_dup_o.rd  = dup_rd;
         end
         default: int_dup_o = instr_i;
      endcase
   end

endmodule

//--- hw/fp_dup_rewriter.sv
`timescale 1ns/10ps

module fp_dup_rewriter import instr_dup_pkg::*; (
   input  rv_instr_t  instr_i,
   input  dup_class_e cls_i,
   input  rv_instr_t  int_dup_i,
   output rv_instr_t  dup_o
);

   logic [INSTR_W-1:0]    raw;     // flat view for the R4 fields
   logic [REG_ADDR_W-1:0] rs3;
   logic [1:0]            fmt;

   logic [REG_ADDR_W-1:0] dup_rd;
   logic [REG_ADDR_W-1:0] dup_rs1;
   logic [REG_ADDR_W-1:0] dup_rs2;
   logic [REG_ADDR_W-1:0] dup_rs3;
   logic [6:0]            mem_hi;

   assign raw = instr_i;
   assign rs3 = raw[31:27];
   assign fmt = raw[26:25];

   assign dup_rd  = map_reg(instr_i.rd);
   assign dup_rs1 = map_reg(instr_i.rs1);
   assign dup_rs2 = map_reg(instr_i.rs2);
   assign dup_rs3 = map_reg(rs3);

   assign mem_hi = {DUP_MEM_PREFIX, instr_i.funct7[0]};

   // ==============================
   // fp formats
   // ==============================
   // int and fp indices map the same way, the class only decides
   // which of rd/rs1 is the integer operand
   always_comb begin
      dup_o = int_dup_i;
      case (cls_i)
         CLS_FP_R2, CLS_FP_R2_F_I, CLS_FP_R2_I_F: begin
            dup_o     = instr_i;         // rs2 slot is part of funct12
            dup_o.rs1 = dup_rs1;
            dup_o.rd  = dup_rd;
         end
         CLS_FP_R3, CLS_FP_R3_I_FF: begin
            dup_o     = instr_i;
            dup_o.rs2 = dup_rs2;
            dup_o.rs1 = dup_rs1;
            dup_o.rd  = dup_rd;          // int dest for compares
         end
         CLS_FP_R4: begin
            dup_o        = instr_i;
            dup_o.funct7 = {dup_rs3, fmt};
            dup_o.rs2    = dup_rs2;
            dup_o.rs1    = dup_rs1;
            dup_o.rd     = dup_rd;
         end
         CLS_FP_LOAD: begin
            dup_o        = instr_i;
            dup_o.funct7 = mem_hi;
            dup_o.rs1    = dup_rs1;      // integer base
            dup_o.rd     = dup_rd;
         end
         CLS_FP_STORE: begin
            dup_o        = instr_i;
            dup_o.funct7 = mem_hi;
            dup_o.rs2    = dup_rs2;      // fp data
            dup_o.rs1    = dup_rs1;
         end
         default: dup_o = int_dup_i;     // integer or unknown
      endcase
   end

endmodule

//--- hw/instr_dup_top.sv
`timescale 1ns/10ps

module instr_dup_top import instr_dup_pkg::*; (
   input  logic       clk,
   input  logic       reset_i,
   input  logic       instr_valid_i,
   input  rv_instr_t  instr_i,
   output logic       dup_valid_o,
   output rv_instr_t  dup_instr_o,
   output dup_class_e dup_class_o
);

   dup_class_e cls;
   rv_instr_t  int_dup;
   rv_instr_t  dup_instr;

   dup_classifier u_classifier (
      .instr_i (instr_i),
      .cls_o   (cls)
   );

   int_dup_rewriter u_int_rewriter (
      .instr_i   (instr_i),
      .cls_i     (cls),
      .int_dup_o (int_dup)
   );

   fp_dup_rewriter u_fp_rewriter (
      .instr_i   (instr_i),
      .cls_i     (cls),
      .int_dup_i (int_dup),
      .dup_o     (dup_instr)
   );

   // ==============================
   // output stage
   // ==============================
   always_ff @(posedge clk) begin
      if (reset_i)
         dup_valid_o <= 1'b0;
      else
         dup_valid_o <= instr_valid_i;
   end

   always_ff @(posedge clk) begin
      if (instr_valid_i) begin
         dup_instr_o <= dup_instr;   // holds while no strobe
         dup_class_o <= cls;
      end
   end

   a_valid_after_reset: assert property (@(posedge clk) reset_i |=> !dup_valid_o);

   a_amo_base: assert property (@(posedge clk) disable iff (reset_i)
      (dup_valid_o && (dup_class_o == CLS_AMO)) |-> (dup_instr_o.rs1 == DUP_R0P));

   a_rd_dup_half: assert property (@(posedge clk) disable iff (reset_i)
      (dup_valid_o && (dup_class_o inside {CLS_ALU_REG, CLS_LOAD}))
      |-> dup_instr_o.rd[DUP_REG_BIT]);

endmodule

//--- verification/tb_instr_dup.sv
`timescale 1ns/10ps

module tb_instr_dup import instr_dup_pkg::*; ();

   localparam int RESET_CYCLES = 16;
   localparam int REPS         = 4;
   // 4 inside reset, 1 single, 4 burst, 18 per rep, 3 pass-through
   localparam int NUM_STROBES    = 9 + REPS * 18 + 3;
   localparam int TIMEOUT_CYCLES = 3 * NUM_STROBES + RESET_CYCLES + 100;
   localparam logic [31:0] LFSR_SEED = 32'hd25f_a389;

   logic       clk;
   logic       reset_i;
   logic       instr_valid_i;
   rv_instr_t  instr_i;
   logic       dup_valid_o;
   rv_instr_t  dup_instr_o;
   dup_class_e dup_class_o;

   logic [31:0] lfsr;
   int          cycles = 0;

   instr_dup_top dut (
      .clk           (clk),
      .reset_i       (reset_i),
      .instr_valid_i (instr_valid_i),
      .instr_i       (instr_i),
      .dup_valid_o   (dup_valid_o),
      .dup_instr_o   (dup_instr_o),
      .dup_class_o   (dup_class_o)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES)
         abort_run($sformatf("timeout after %0d cycles, the tests did not finish", cycles));
   end

   // ==============================
   // stimulus helpers
   // ==============================
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      logic        fb;
      int          k;
      v = '0;
      for (k = 0; k < n; k++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];   // taps 32 22 2 1
         lfsr = {lfsr[30:0], fb};
         v    = {v[30:0], fb};
      end
      return v;
   endfunction

   function automatic rv_instr_t rand_op(input logic [6:0] opcode);
      rv_instr_t s;
      s        = rand_bits(32);
      s.opcode = opcode;
      return s;
   endfunction

   // twin index is the same index with bit 4 set
   function automatic rv_instr_t twin_regs(input rv_instr_t s, input logic rd,
                                           input logic rs1, input logic rs2);
      rv_instr_t d;
      d = s;
      if (rd) d.rd = {1'b1, s.rd[3:0]};
      if (rs1) d.rs1 = {1'b1, s.rs1[3:0]};
      if (rs2) d.rs2 = {1'b1, s.rs2[3:0]};
      return d;
   endfunction

   // ==============================
   // checks
   // ==============================
   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("TESTS FAILED");
      $fatal(1, "run stopped");
   endtask

   task automatic check_instr(input string name, input rv_instr_t exp, input rv_instr_t act);
      if (act !== exp)
         abort_run($sformatf("ERR %s expected %h actual %h", name, exp, act));
   endtask

   task automatic check_class(input string name, input dup_class_e exp, input dup_class_e act);
      if (act !== exp)
         abort_run($sformatf("ERR %s expected %s actual %s (%0d)",
                             name, exp.name(), act.name(), act));
   endtask

   task automatic check_valid(input string name, input logic exp, input logic act);
      if (act !== exp)
         abort_run($sformatf("ERR %s expected valid %b actual %b", name, exp, act));
   endtask

   // one strobe and its result one edge later
   task automatic run_one(input string name, input rv_instr_t src, input rv_instr_t want,
                          input dup_class_e want_cls);
      @(posedge clk);
      instr_valid_i <= 1'b1;
      instr_i       <= src;
      @(negedge clk);
      check_valid(name, 1'b0, dup_valid_o);   // idle edge before the strobe
      @(posedge clk);
      instr_valid_i <= 1'b0;
      @(negedge clk);
      check_valid(name, 1'b1, dup_valid_o);
      check_instr(name, want, dup_instr_o);
      check_class(name, want_cls, dup_class_o);
   endtask

   // ==============================
   // tests
   // ==============================
   task automatic test_reset_strobe();
      rv_instr_t burst_in [4];
      rv_instr_t burst_want [4];
      rv_instr_t src;
      int        i;
      for (i = 1; i <= RESET_CYCLES; i++) begin
         @(posedge clk);
         // strobes swallowed by reset, the last one on the final reset edge
         instr_valid_i <= (i > RESET_CYCLES - 5) && (i < RESET_CYCLES);
         instr_i       <= rand_op(OP);
         if (i == RESET_CYCLES) reset_i <= 1'b0;
         @(negedge clk);
         check_valid("reset", 1'b0, dup_valid_o);
      end
      @(posedge clk);
      @(negedge clk);
      check_valid("reset_release", 1'b0, dup_valid_o);
      src = rand_op(OP);
      run_one("single", src, twin_regs(src, 1'b1, 1'b1, 1'b1), CLS_ALU_REG);
      for (i = 0; i < 4; i++) begin
         burst_in[i]   = rand_op(OP_IMM);
         burst_want[i] = twin_regs(burst_in[i], 1'b1, 1'b1, 1'b0);
      end
      for (i = 0; i <= 4; i++) begin
         @(posedge clk);
         instr_valid_i <= (i < 4);
         instr_i       <= (i < 4) ? burst_in[i] : rand_op(LUI);
         @(negedge clk);
         check_valid("burst", i > 0, dup_valid_o);
         if (i > 0) begin
            check_instr("burst", burst_want[i-1], dup_instr_o);
            check_class("burst", CLS_ALU_IMM, dup_class_o);
         end
      end
      @(posedge clk);
      @(negedge clk);
      check_valid("hold", 1'b0, dup_valid_o);
      check_instr("hold", burst_want[3], dup_instr_o);
      check_class("hold", CLS_ALU_IMM, dup_class_o);
   endtask

   task automatic test_alu();
      rv_instr_t src;
      int        r;
      for (r = 0; r < REPS; r++) begin
         src = rand_op(OP);
         run_one("alu_reg", src, twin_regs(src, 1'b1, 1'b1, 1'b1), CLS_ALU_REG);
         src = rand_op(OP_IMM);
         run_one("alu_imm", src, twin_regs(src, 1'b1, 1'b1, 1'b0), CLS_ALU_IMM);
      end
   endtask

   task automatic test_mem();
      rv_instr_t src;
      rv_instr_t want;
      int        r;
      for (r = 0; r < REPS; r++) begin
         src        = rand_op(LOAD);
         src.funct3 = 3'(rand_bits(3));
         if (src.funct3 inside {3'd3, 3'd6, 3'd7}) src.funct3 = LW;
         want = twin_regs(src, 1'b1, 1'b1, 1'b0);
         {want.funct7, want.rs2} = {DUP_MEM_PREFIX, src.funct7[0], src.rs2}; // imm[5:0]
         run_one("load", src, want, CLS_LOAD);
         src        = rand_op(STORE);
         src.funct3 = 3'(rand_bits(2));
         if (src.funct3 == 3'd3) src.funct3 = SW;
         want        = twin_regs(src, 1'b0, 1'b1, 1'b1);
         want.funct7 = {DUP_MEM_PREFIX, src.funct7[0]};   // low five bits sit in rd
         run_one("store", src, want, CLS_STORE);
      end
   endtask

   task automatic test_ctrl();
      rv_instr_t src;
      rv_instr_t want;
      int        r;
      for (r = 0; r < REPS; r++) begin
         src = rand_op(JAL);
         run_one("jal", src, twin_regs(src, 1'b1, 1'b0, 1'b0), CLS_JAL);
         src        = rand_op(JALR);
         src.funct3 = 3'b000;
         run_one("jalr", src, twin_regs(src, 1'b1, 1'b1, 1'b0), CLS_JALR);
         src = rand_op(LUI);
         run_one("lui", src, twin_regs(src, 1'b1, 1'b0, 1'b0), CLS_UPPER);
         src = rand_op(AUIPC);
         run_one("auipc", src, twin_regs(src, 1'b1, 1'b0, 1'b0), CLS_UPPER);
         src = rand_op(BRANCH);
         run_one("branch", src, twin_regs(src, 1'b0, 1'b1, 1'b1), CLS_BRANCH);
         src        = rand_op(AMO);
         src.funct3 = 3'b010;
         want       = twin_regs(src, 1'b1, 1'b0, 1'b1);
         want.rs1   = 5'd16;
         run_one("amo", src, want, CLS_AMO);
      end
   endtask

   task automatic test_fp();
      rv_instr_t src;
      rv_instr_t want;
      int        r;
      for (r = 0; r < REPS; r++) begin
         src        = rand_op(OP_FP);
         src.funct7 = {2'b00, 3'(rand_bits(3) % 6), 1'b0, 1'(rand_bits(1))};
         run_one("fp_r3", src, twin_regs(src, 1'b1, 1'b1, 1'b1), CLS_FP_R3);
         src  = rand_op({3'b100, 2'(rand_bits(2)), 2'b11});   // madd .. nmadd
         want = twin_regs(src, 1'b1, 1'b1, 1'b1);
         want.funct7[6:2] = {1'b1, src.funct7[5:2]};          // rs3
         run_one("fp_r4", src, want, CLS_FP_R4);
         src        = rand_op(OP_FP);
         src.funct7 = {6'b110100, 1'(rand_bits(1))};
         src.rs2    = {4'b0000, 1'(rand_bits(1))};
         run_one("fcvt_f_w", src, twin_regs(src, 1'b1, 1'b1, 1'b0), CLS_FP_R2_F_I);
         src        = rand_op(OP_FP);
         src.funct7 = {6'b110000, 1'(rand_bits(1))};
         src.rs2    = {4'b0000, 1'(rand_bits(1))};
         run_one("fcvt_w_f", src, twin_regs(src, 1'b1, 1'b1, 1'b0), CLS_FP_R2_I_F);
         src        = rand_op(OP_FP);
         src.funct7 = {6'b101000, 1'(rand_bits(1))};
         src.funct3 = 3'(rand_bits(2) % 3);
         run_one("fp_cmp", src, twin_regs(src, 1'b1, 1'b1, 1'b1), CLS_FP_R3_I_FF);
         src        = rand_op(OP_FP);
         src.funct7 = {6'b010110, 1'(rand_bits(1))};
         src.rs2    = 5'd0;
         run_one("fsqrt", src, twin_regs(src, 1'b1, 1'b1, 1'b0), CLS_FP_R2);
         src        = rand_op(LOAD_FP);
         src.funct3 = 3'(rand_bits(2)) + 3'd1;
         want       = twin_regs(src, 1'b1, 1'b1, 1'b0);
         {want.funct7, want.rs2} = {DUP_MEM_PREFIX, src.funct7[0], src.rs2};
         run_one("fp_load", src, want, CLS_FP_LOAD);
         src         = rand_op(STORE_FP);
         src.funct3  = 3'(rand_bits(2)) + 3'd1;
         want        = twin_regs(src, 1'b0, 1'b1, 1'b1);
         want.funct7 = {DUP_MEM_PREFIX, src.funct7[0]};
         run_one("fp_store", src, want, CLS_FP_STORE);
      end
   endtask

   task automatic test_pass_through();
      rv_instr_t src;
      src = rand_op(7'h7f);
      run_one("unknown_opcode", src, src, CLS_NONE);
      src        = rand_op(OP_FP);
      src.funct7 = 7'b0101100;   // fsqrt code with a nonzero rs2
      src.rs2    = 5'd1;
      run_one("fp_bad_funct12", src, src, CLS_NONE);
      src        = rand_op(LOAD);
      src.funct3 = 3'b011;
      run_one("load_bad_width", src, src, CLS_NONE);
   endtask

   initial begin
      reset_i       = 1'b1;
      instr_valid_i = 1'b0;
      instr_i       = '0;
      lfsr          = LFSR_SEED;
      test_reset_strobe();
      test_alu();
      test_mem();
      test_ctrl();
      test_fp();
      test_pass_through();
      $display("TESTS PASSED");
      $finish;
   end

endmodule

//--- tb.f
hw/instr_dup_pkg.sv
hw/dup_classifier.sv
hw/int_dup_rewriter.sv
hw/fp_dup_rewriter.sv
hw/instr_dup_top.sv
verification/tb_instr_dup.sv

//--- Bender.yml
package:
  name: instr_dup

sources:
  - files:
      - hw/instr_dup_pkg.sv
      - hw/dup_classifier.sv
      - hw/int_dup_rewriter.sv
      - hw/fp_dup_rewriter.sv
      - hw/instr_dup_top.sv
  - target: test
    files:
      - verification/tb_instr_dup.sv
